// File: design/jesd_pkg.sv
// ********************
// Shared widths and beat types for the JESD204-style loopback data path.
// Imported by every transport, scrambler and top-level module and by the
// testbench, so that both sides agree on the lane word layout.
// ********************

`default_nettype none

package jesd_pkg;

  // Converter sample width, matching the DMA sample width of the converters
  localparam int sample_w = 16;

  // One lane word carries four octets per device_clk cycle
  localparam int lane_w = 32;
  localparam int octets_per_lane = lane_w / 8;

  // Length of the scrambler history for 1 + x^14 + x^15
  localparam int scr_hist_w = 15;

  typedef logic [sample_w-1:0] sample_t;

  // The same lane word seen as one bit vector or as four octets
  // Octet 3 sits in bits 31:24 and is the first octet on the lane
  typedef union packed {
    logic [lane_w-1:0] word;
    logic [octets_per_lane-1:0][7:0] octet;
  } lane_word_u;

  // One lane word plus the controls that travel with it
  typedef struct packed {
    logic valid;
    logic scr_en;
    lane_word_u data;
  } lane_beat_t;

  // Controls of one sample beat
  // The sample array travels beside it because its shape is parameterized
  typedef struct packed {
    logic valid;
    logic scr_en;
  } sample_beat_t;

endpackage

`default_nettype wire

// File: design/jesd_tx_transport.sv
// ********************
// Transmit transport layer. Packs one beat of converter samples into
// num_lanes lane words and registers them, one cycle of latency.
// ********************

`default_nettype none

module jesd_tx_transport #(
  parameter int num_conv = 4,
  parameter int num_lanes = 4,
  localparam int samples_per_conv =
    (num_lanes * jesd_pkg::lane_w) / (num_conv * jesd_pkg::sample_w)
) (
  input  logic                   device_clk,
  input  logic                   arst_n,
  input  jesd_pkg::sample_beat_t in_beat,
  input  jesd_pkg::sample_t      in_samples [num_conv][samples_per_conv],
  output jesd_pkg::lane_beat_t   tx_lanes [num_lanes]
);

  import jesd_pkg::*;

  // Lane words before the output register
  lane_word_u packed_words [num_lanes];

  // ********************
  // Packing
  // ********************

  // Sample k owns flat octets 2k (high byte) and 2k+1 (low byte)
  // Flat octet b lands in lane b / 4 at octet position 3 - b % 4,
  // so the lowest flat octet of a lane goes out first
  always_comb begin
    int hi_oct;
    int lo_oct;
    for (int l = 0; l < num_lanes; l++) begin
      packed_words[l].word = '0;
    end
    for (int c = 0; c < num_conv; c++) begin
      for (int s = 0; s < samples_per_conv; s++) begin
        hi_oct = 2 * (c * samples_per_conv + s);
        lo_oct = hi_oct + 1;
        packed_words[hi_oct / octets_per_lane].octet[octets_per_lane - 1 -
          hi_oct % octets_per_lane] = in_samples[c][s][sample_w-1:8];
        packed_words[lo_oct / octets_per_lane].octet[octets_per_lane - 1 -
          lo_oct % octets_per_lane] = in_samples[c][s][7:0];
      end
    end
  end

  // ********************
  // Output register
  // ********************

  // Every lane carries a copy of the beat controls so the lanes stay in lockstep
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int l = 0; l < num_lanes; l++) begin
        tx_lanes[l] <= '0;
      end
    end else begin
      for (int l = 0; l < num_lanes; l++) begin
        tx_lanes[l].valid  <= in_beat.valid;
        tx_lanes[l].scr_en <= in_beat.scr_en;
        tx_lanes[l].data   <= packed_words[l];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/jesd_lane_scrambler.sv
// ********************
// Self-synchronous scrambler for one lane, polynomial 1 + x^14 + x^15.
// With descramble set the same block undoes the scrambling on the receive side.
// ********************

`default_nettype none

module jesd_lane_scrambler #(
  parameter bit descramble = 1'b0
) (
  input  logic                 device_clk,
  input  logic                 arst_n,
  input  jesd_pkg::lane_beat_t lane_in,
  output jesd_pkg::lane_beat_t lane_out
);

  import jesd_pkg::*;

  // Bit 0 holds the most recent lane bit and bit 14 the oldest
  logic [scr_hist_w-1:0] hist_q;
  logic [scr_hist_w-1:0] hist_next;
  logic [lane_w-1:0]     word_next;

  // ********************
  // Bit recursion
  // ********************

  // Bits are processed in transmit order, MSB first
  // Each output bit is the input bit XOR the lane bits 14 and 15 positions back
  always_comb begin
    logic in_bit;
    logic out_bit;
    logic feedback;
    hist_next = hist_q;
    word_next = lane_in.data.word;
    for (int i = lane_w - 1; i >= 0; i--) begin
      in_bit   = lane_in.data.word[i];
      feedback = hist_next[13] ^ hist_next[14];
      if (lane_in.scr_en) begin
        out_bit = in_bit ^ feedback;
      end else begin
        out_bit = in_bit;
      end
      word_next[i] = out_bit;
      // The history always follows the bits as they appear on the lane,
      // which is the output when scrambling and the input when descrambling
      if (descramble) begin
        hist_next = {hist_next[scr_hist_w-2:0], in_bit};
      end else begin
        hist_next = {hist_next[scr_hist_w-2:0], out_bit};
      end
    end
  end

  // ********************
  // Registers
  // ********************

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      hist_q   <= '0;
      lane_out <= '0;
    end else begin
      // Bubbles leave the history alone
      if (lane_in.valid) begin
        hist_q <= hist_next;
      end
      lane_out.valid     <= lane_in.valid;
      lane_out.scr_en    <= lane_in.scr_en;
      lane_out.data.word <= word_next;
    end
  end

endmodule

`default_nettype wire

// File: design/jesd_rx_transport.sv
// ********************
// Receive transport layer. Gathers the octets of each sample back out of
// the lane words and registers the samples, one cycle of latency.
// ********************

`default_nettype none

module jesd_rx_transport #(
  parameter int num_conv = 4,
  parameter int num_lanes = 4,
  localparam int samples_per_conv =
    (num_lanes * jesd_pkg::lane_w) / (num_conv * jesd_pkg::sample_w)
) (
  input  logic                   device_clk,
  input  logic                   arst_n,
  input  jesd_pkg::lane_beat_t   rx_lanes [num_lanes],
  output jesd_pkg::sample_beat_t out_beat,
  output jesd_pkg::sample_t      out_samples [num_conv][samples_per_conv]
);

  import jesd_pkg::*;

  // Samples rebuilt from the lane words before the output register
  sample_t unpacked [num_conv][samples_per_conv];

  // ********************
  // Unpacking
  // ********************

  // Inverse of the transmit packing: flat octet 2k is the high byte of
  // sample k and flat octet 2k+1 its low byte
  always_comb begin
    int hi_oct;
    int lo_oct;
    for (int c = 0; c < num_conv; c++) begin
      for (int s = 0; s < samples_per_conv; s++) begin
        hi_oct = 2 * (c * samples_per_conv + s);
        lo_oct = hi_oct + 1;
        unpacked[c][s][sample_w-1:8] = rx_lanes[hi_oct / octets_per_lane].data.octet[
          octets_per_lane - 1 - hi_oct % octets_per_lane];
        unpacked[c][s][7:0] = rx_lanes[lo_oct / octets_per_lane].data.octet[
          octets_per_lane - 1 - lo_oct % octets_per_lane];
      end
    end
  end

  // ********************
  // Output register
  // ********************

  // All lanes move in lockstep, so lane 0 speaks for the beat controls
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_beat    <= '0;
      out_samples <= '{default: '0};
    end else begin
      out_beat.valid  <= rx_lanes[0].valid;
      out_beat.scr_en <= rx_lanes[0].scr_en;
      out_samples     <= unpacked;
    end
  end

endmodule

`default_nettype wire

// File: design/jesd_link_loopback.sv
// ********************
// Loopback top: transmit transport, per-lane scramblers and descramblers,
// then receive transport. The scrambled lanes are exposed on lane_out.
// Latency is 2 cycles to lane_out and 4 cycles to out_beat.
// ********************

`default_nettype none

module jesd_link_loopback #(
  parameter int num_conv = 4,
  parameter int num_lanes = 4,
  localparam int samples_per_conv =
    (num_lanes * jesd_pkg::lane_w) / (num_conv * jesd_pkg::sample_w)
) (
  input  logic                   device_clk,
  input  logic                   arst_n,
  input  jesd_pkg::sample_beat_t in_beat,
  input  jesd_pkg::sample_t      in_samples [num_conv][samples_per_conv],
  output jesd_pkg::lane_beat_t   lane_out [num_lanes],
  output jesd_pkg::sample_beat_t out_beat,
  output jesd_pkg::sample_t      out_samples [num_conv][samples_per_conv]
);

  import jesd_pkg::*;

  // Lane beats between the stages
  lane_beat_t tx_lanes  [num_lanes];
  lane_beat_t scr_lanes [num_lanes];
  lane_beat_t rx_lanes  [num_lanes];

  jesd_tx_transport #(
    .num_conv  (num_conv),
    .num_lanes (num_lanes)
  ) i_tx_transport (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .in_beat    (in_beat),
    .in_samples (in_samples),
    .tx_lanes   (tx_lanes)
  );

  // ********************
  // Per-lane scrambling
  // ********************

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    jesd_lane_scrambler #(
      .descramble (1'b0)
    ) i_scrambler (
      .device_clk (device_clk),
      .arst_n     (arst_n),
      .lane_in    (tx_lanes[l]),
      .lane_out   (scr_lanes[l])
    );

    // The lanes loop straight back into the receive side
    jesd_lane_scrambler #(
      .descramble (1'b1)
    ) i_descrambler (
      .device_clk (device_clk),
      .arst_n     (arst_n),
      .lane_in    (scr_lanes[l]),
      .lane_out   (rx_lanes[l])
    );
  end

  assign lane_out = scr_lanes;

  jesd_rx_transport #(
    .num_conv  (num_conv),
    .num_lanes (num_lanes)
  ) i_rx_transport (
    .device_clk  (device_clk),
    .arst_n      (arst_n),
    .rx_lanes    (rx_lanes),
    .out_beat    (out_beat),
    .out_samples (out_samples)
  );

endmodule

`default_nettype wire

// File: tests/jesd_link_loopback_tb.sv
// ********************
// Table-driven testbench for the JESD204-style loopback. It drives sample
// beats row by row, predicts the lane words with its own packing and
// scrambler models, and checks lane_out and out_samples at fixed latency.
// ********************

`default_nettype none

module jesd_link_loopback_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import jesd_pkg::*;

  localparam int num_conv = 4;
  localparam int num_lanes = 4;
  localparam int samples_per_conv = (num_lanes * lane_w) / (num_conv * sample_w);
  localparam int num_smp = num_conv * samples_per_conv;
  localparam int num_tests = 8;
  localparam int wait_limit = 16;

  localparam logic [1:0] pat_nibble = 2'd0;
  localparam logic [1:0] pat_count  = 2'd1;
  localparam logic [1:0] pat_random = 2'd2;
  localparam logic [1:0] scr_off    = 2'd0;
  localparam logic [1:0] scr_on     = 2'd1;
  localparam logic [1:0] scr_toggle = 2'd2;

  typedef logic [8*10-1:0] name_t;
  typedef logic [num_lanes-1:0][lane_w-1:0] lane_vec_t;
  typedef logic [num_smp-1:0][sample_w-1:0] flat_smp_t;

  // One row of the stimulus table
  typedef struct packed {
    name_t      name;
    logic [1:0] kind;
    logic [1:0] scr_mode;
    logic [7:0] beats;
    logic       gaps;
  } test_row_t;

  // Everything the monitors need to know about one driven beat
  typedef struct packed {
    int        cycle;
    logic [7:0] row;
    logic      scr_en;
    lane_vec_t words;
    flat_smp_t samples;
  } exp_beat_t;

  localparam test_row_t tests [num_tests] = '{
    '{"nibble_raw", pat_nibble, scr_off,    8'd4,  1'b0},
    '{"counts_raw", pat_count,  scr_off,    8'd6,  1'b0},
    '{"nibble_scr", pat_nibble, scr_on,     8'd6,  1'b0},
    '{"counts_scr", pat_count,  scr_on,     8'd8,  1'b0},
    '{"random_scr", pat_random, scr_on,     8'd12, 1'b1},
    '{"random_raw", pat_random, scr_off,    8'd8,  1'b1},
    '{"toggle_scr", pat_random, scr_toggle, 8'd12, 1'b0},
    '{"toggle_gap", pat_count,  scr_toggle, 8'd10, 1'b1}
  };

  logic         device_clk;
  logic         arst_n;
  sample_beat_t in_beat;
  sample_t      in_samples [num_conv][samples_per_conv];
  lane_beat_t   lane_out [num_lanes];
  sample_beat_t out_beat;
  sample_t      out_samples [num_conv][samples_per_conv];

  int cycle = 0;
  int total_beats;
  int lane_errs = 0;
  int sample_errs = 0;
  int beat_errs = 0;
  int other_errs = 0;

  // Scrambler model history per lane, newest bit in bit 0
  logic [scr_hist_w-1:0] tx_past [num_lanes];
  exp_beat_t exp_lane_q [$];
  exp_beat_t exp_smp_q [$];

  jesd_link_loopback #(
    .num_conv  (num_conv),
    .num_lanes (num_lanes)
  ) i_dut (
    .device_clk  (device_clk),
    .arst_n      (arst_n),
    .in_beat     (in_beat),
    .in_samples  (in_samples),
    .lane_out    (lane_out),
    .out_beat    (out_beat),
    .out_samples (out_samples)
  );

  initial begin
    device_clk = 1'b0;
    forever #5 device_clk = ~device_clk;
  end

  always @(posedge device_clk) cycle <= cycle + 1;

  // ********************
  // Reference models
  // ********************

  // Walks every lane octet and looks up which sample byte lands there
  function automatic lane_vec_t pack_model(input flat_smp_t flat);
    lane_vec_t words;
    int b;
    for (int l = 0; l < num_lanes; l++) begin
      for (int p = 0; p < 4; p++) begin
        b = 4 * l + (3 - p);
        if (b % 2 == 0) begin
          words[l][8*p +: 8] = flat[b / 2][15:8];
        end else begin
          words[l][8*p +: 8] = flat[b / 2][7:0];
        end
      end
    end
    return words;
  endfunction

  // Serial 1 + x^14 + x^15 scrambler, first lane bit is bit 31
  task automatic scramble_model(input logic [lane_w-1:0] data, input bit en,
                                inout logic [scr_hist_w-1:0] past,
                                output logic [lane_w-1:0] lane_bits);
    logic bit_out;
    for (int i = lane_w - 1; i >= 0; i--) begin
      bit_out = en ? (data[i] ^ past[13] ^ past[14]) : data[i];
      lane_bits[i] = bit_out;
      past = {past[scr_hist_w-2:0], bit_out};
    end
  endtask

  // ********************
  // Compare tasks
  // ********************

  task automatic check_lanes(input name_t name, input int lane, input lane_beat_t exp,
                             input lane_beat_t act);
    if (act !== exp) begin
      lane_errs++;
      $display("FAIL %0s lane %0d expected %h actual %h", name, lane, exp, act);
    end
  endtask

  task automatic check_beat(input name_t name, input sample_beat_t exp,
                            input sample_beat_t act);
    if (act !== exp) begin
      beat_errs++;
      $display("FAIL %0s out_beat expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_samples(input name_t name,
                               input sample_t exp [num_conv][samples_per_conv],
                               input sample_t act [num_conv][samples_per_conv]);
    for (int c = 0; c < num_conv; c++) begin
      for (int s = 0; s < samples_per_conv; s++) begin
        if (act[c][s] !== exp[c][s]) begin
          sample_errs++;
          $display("FAIL %0s conv %0d sample %0d expected %h actual %h",
                   name, c, s, exp[c][s], act[c][s]);
        end
      end
    end
  endtask

  // ********************
  // Stimulus
  // ********************

  task automatic drive_all();
    exp_beat_t rec;
    sample_t smp [num_conv][samples_per_conv];
    flat_smp_t flat;
    lane_vec_t raw;
    logic [scr_hist_w-1:0] hist;
    logic [lane_w-1:0] scr_word;
    logic [7:0] count;
    bit scr;
    int unsigned gap;
    count = 8'd0;
    for (int r = 0; r < num_tests; r++) begin
      for (int b = 0; b < int'(tests[r].beats); b++) begin
        // Toggle rows start with scrambling off on the first beat
        scr = (tests[r].scr_mode == scr_toggle) ? b[0] : tests[r].scr_mode[0];
        for (int c = 0; c < num_conv; c++) begin
          for (int s = 0; s < samples_per_conv; s++) begin
            case (tests[r].kind)
              pat_nibble: smp[c][s] = {4{c[3:0]}};
              pat_count: begin
                smp[c][s] = {c[3:0], 4'h0, count};
                count = count + 8'd1;
              end
              default: smp[c][s] = sample_t'($urandom);
            endcase
            flat[c * samples_per_conv + s] = smp[c][s];
          end
        end
        raw = pack_model(flat);
        for (int l = 0; l < num_lanes; l++) begin
          hist = tx_past[l];
          scramble_model(raw[l], scr, hist, scr_word);
          tx_past[l] = hist;
          rec.words[l] = scr_word;
        end
        rec.samples = flat;
        rec.row = r[7:0];
        rec.scr_en = scr;
        @(posedge device_clk);
        #1;
        in_beat.valid = 1'b1;
        in_beat.scr_en = scr;
        in_samples = smp;
        rec.cycle = cycle;
        exp_lane_q.push_back(rec);
        exp_smp_q.push_back(rec);
        gap = tests[r].gaps ? $urandom_range(0, 3) : 0;
        // Bubbles carry junk samples with scr_en set, which must not move the history
        repeat (gap) begin
          @(posedge device_clk);
          #1;
          in_beat.valid = 1'b0;
          in_beat.scr_en = 1'b1;
          for (int c = 0; c < num_conv; c++) begin
            for (int s = 0; s < samples_per_conv; s++) begin
              in_samples[c][s] = sample_t'($urandom);
            end
          end
        end
      end
    end
    @(posedge device_clk);
    #1;
    in_beat = '0;
  endtask

  // ********************
  // Monitors
  // ********************

  // Polls a valid flag on falling edges until it shows up or the limit runs out
  task automatic wait_for_valid(input bit at_rx, output bit seen);
    int cnt;
    cnt = 0;
    seen = 1'b0;
    while (!seen && cnt < wait_limit) begin
      @(negedge device_clk);
      cnt++;
      seen = at_rx ? out_beat.valid : lane_out[0].valid;
    end
  endtask

  task automatic watch_lanes();
    exp_beat_t rec;
    lane_beat_t exp;
    bit seen;
    for (int i = 0; i < total_beats; i++) begin
      wait_for_valid(1'b0, seen);
      if (!seen || exp_lane_q.size() == 0) begin
        other_errs++;
        $display("Timeout: lane beat %0d never appeared on lane_out", i);
        return;
      end
      rec = exp_lane_q.pop_front();
      if (cycle != rec.cycle + 2) begin
        other_errs++;
        $display("Lane beat %0d of %0s came out at cycle %0d instead of %0d",
                 i, tests[rec.row].name, cycle, rec.cycle + 2);
      end
      for (int l = 0; l < num_lanes; l++) begin
        exp.valid = 1'b1;
        exp.scr_en = rec.scr_en;
        exp.data.word = rec.words[l];
        check_lanes(tests[rec.row].name, l, exp, lane_out[l]);
      end
    end
  endtask

  task automatic watch_samples();
    exp_beat_t rec;
    sample_beat_t exp_beat;
    sample_t exp_smp [num_conv][samples_per_conv];
    bit seen;
    for (int i = 0; i < total_beats; i++) begin
      wait_for_valid(1'b1, seen);
      if (!seen || exp_smp_q.size() == 0) begin
        other_errs++;
        $display("Timeout: sample beat %0d never appeared on out_beat", i);
        return;
      end
      rec = exp_smp_q.pop_front();
      if (cycle != rec.cycle + 4) begin
        other_errs++;
        $display("Sample beat %0d of %0s came out at cycle %0d instead of %0d",
                 i, tests[rec.row].name, cycle, rec.cycle + 4);
      end
      for (int k = 0; k < num_smp; k++) begin
        exp_smp[k / samples_per_conv][k % samples_per_conv] = rec.samples[k];
      end
      exp_beat.valid = 1'b1;
      exp_beat.scr_en = rec.scr_en;
      check_beat(tests[rec.row].name, exp_beat, out_beat);
      check_samples(tests[rec.row].name, exp_smp, out_samples);
    end
  endtask

  // Nothing may come out before the first input beat
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge device_clk);
      for (int l = 0; l < num_lanes; l++) begin
        if (lane_out[l].valid !== 1'b0) begin
          other_errs++;
          $display("lane_out %0d shows a valid beat before any input", l);
        end
      end
      if (out_beat.valid !== 1'b0) begin
        other_errs++;
        $display("out_beat shows a valid beat before any input");
      end
    end
  endtask

  initial begin
    void'($urandom(32'h9145_f382));
    arst_n = 1'b0;
    in_beat = '0;
    in_samples = '{default: '0};
    total_beats = 0;
    for (int l = 0; l < num_lanes; l++) begin
      tx_past[l] = '0;
    end
    for (int r = 0; r < num_tests; r++) begin
      total_beats += int'(tests[r].beats);
    end
    repeat (3) @(posedge device_clk);
    #1;
    arst_n = 1'b1;
    check_idle(4);
    fork
      drive_all();
      watch_lanes();
      watch_samples();
    join
    $display("Errors: lane %0d, sample %0d, beat %0d, other %0d",
             lane_errs, sample_errs, beat_errs, other_errs);
    if (lane_errs + sample_errs + beat_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: jesd_link_loopback.f
design/jesd_pkg.sv
design/jesd_tx_transport.sv
design/jesd_lane_scrambler.sv
design/jesd_rx_transport.sv
design/jesd_link_loopback.sv
tests/jesd_link_loopback_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the loopback testbench with Verilator and runs it.
# The exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  -f jesd_link_loopback.f \
  --top-module jesd_link_loopback_tb \
  -o jesd_link_loopback_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/jesd_link_loopback_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
